//--- list.f
src/afu_pkg.sv
src/cmd_if.sv
src/parity_workelement.sv
src/line_buffer.sv
src/command_encoder.sv
src/parity_afu.sv
sim/parity_afu_chk.sv
sim/tb_parity_afu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module tb_parity_afu -Mdir obj_dir
output=$(./obj_dir/Vtb_parity_afu +verilator+error+limit+1000) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
  exit 0
fi
exit 1

//--- sim/tb_parity_afu.sv
`timescale 1ns/100ps

module tb_parity_afu import afu_pkg::*; ();

  localparam int LINE_BEATS = 2;
  localparam int AW = $clog2(LINE_BEATS);
  localparam int BEAT_BYTES = 64;
  localparam int NUM_JOBS = 4;
  localparam int LINE_CYCLES = 60;
  localparam int JOB_CYCLES = 80;

  typedef struct {
    addr_t wed;
    addr_t size;
    addr_t stripe1;
    addr_t stripe2;
    addr_t parity;
    int lines;
  } job_t;

  typedef struct {
    cmd_code_t code;
    tag_t tag;
    addr_t address;
    size_t size;
  } host_cmd_t;

  logic clock;
  logic reset;
  logic enabled;
  addr_t wed;
  logic write_valid;
  tag_t write_tag;
  logic [AW-1:0] write_address;
  beat_t write_data;
  logic read_valid;
  tag_t read_tag;
  logic [AW-1:0] read_address;
  logic response_valid;
  tag_t response_tag;
  logic command_valid;
  cmd_code_t command_code;
  tag_t command_tag;
  addr_t command_address;
  size_t command_size;
  logic command_parity;
  logic tag_parity;
  logic address_parity;
  beat_t read_data;
  logic read_parity;

  // unwritten bytes of the sparse host memory read back a fill pattern
  logic [7:0] memory [addr_t];
  host_cmd_t pending [$];
  job_t current;
  logic [31:0] rng_state;
  int cmd_count;
  int jobs_done;
  int check_count;
  int error_count;

  parity_afu #(
    .LINE_BEATS(LINE_BEATS)
  ) dut (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // wed, size, stripe 1, stripe 2, parity, expected line count
  function automatic job_t job_row(input int i);
    case (i)
      0: return job_t'{64'h1000, 64'd384, 64'h10000, 64'h20000, 64'h30000, 3};
      1: return job_t'{64'h1100, 64'd128, 64'h11000, 64'h21000, 64'h31000, 1};
      2: return job_t'{64'h1200, 64'd200, 64'h12000, 64'h22000, 64'h32000, 2};
      default: return job_t'{64'h1300, 64'd100, 64'h13000, 64'h23000, 64'h33000, 1};
    endcase
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] fill_byte(input addr_t a);
    logic [7:0] folded;
    folded = 8'h5a;
    for (int i = 0; i < 8; i++) begin
      folded = folded ^ a[i*8 +: 8];
    end
    return folded;
  endfunction

  function automatic logic [7:0] mem_byte(input addr_t a);
    return memory.exists(a) ? memory[a] : fill_byte(a);
  endfunction

  // bit that makes the total count of ones odd
  function automatic logic odd_parity(input logic [511:0] v);
    return ($countones(v) % 2) == 0;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("** Error %s: got %h, expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  task automatic load_job(input job_t row);
    int i;
    // descriptor words are stored little-endian
    for (i = 0; i < 8; i++) begin
      memory[row.wed + addr_t'(i)] = row.size[i*8 +: 8];
      memory[row.wed + addr_t'(8 + i)] = row.stripe1[i*8 +: 8];
      memory[row.wed + addr_t'(16 + i)] = row.stripe2[i*8 +: 8];
      memory[row.wed + addr_t'(24 + i)] = row.parity[i*8 +: 8];
    end
    memory[row.wed + 64'd32] = 8'h00;
    for (i = 0; i < row.lines * LINE_BYTES; i++) begin
      rng_state = lcg_next(rng_state);
      memory[row.stripe1 + addr_t'(i)] = rng_state[31:24];
      rng_state = lcg_next(rng_state);
      memory[row.stripe2 + addr_t'(i)] = rng_state[31:24];
    end
  endtask

  // WED read, then S1 read, S2 read, parity write per line, then the done write
  task automatic check_command();
    int line;
    addr_t offset;
    cmd_code_t code;
    tag_t tag;
    addr_t address;
    size_t size;
    line = (cmd_count - 1) / 3;
    offset = addr_t'(line) * 64'd128;
    code = READ_CL_NA;
    tag = WED_TAG;
    address = current.wed;
    size = 12'd32;
    if (cmd_count > 0 && line >= current.lines) begin
      code = WRITE_NA;
      tag = DONE_WRITE;
      address = current.wed + 64'd32;
      size = 12'd1;
    end else if (cmd_count > 0) begin
      size = 12'd128;
      case ((cmd_count - 1) % 3)
        0: begin
          tag = STRIPE1_READ;
          address = current.stripe1 + offset;
        end
        1: begin
          tag = STRIPE2_READ;
          address = current.stripe2 + offset;
        end
        default: begin
          code = WRITE_NA;
          tag = PARITY_WRITE;
          address = current.parity + offset;
        end
      endcase
    end
    check_value("command_code", 64'(command_code), 64'(code));
    check_value("command_tag", 64'(command_tag), 64'(tag));
    check_value("command_address", command_address, address);
    check_value("command_size", 64'(command_size), 64'(size));
    check_value("command_parity", 64'(command_parity), 64'(odd_parity(512'(code))));
    check_value("tag_parity", 64'(tag_parity), 64'(odd_parity(512'(tag))));
    check_value("address_parity", 64'(address_parity), 64'(odd_parity(512'(address))));
    cmd_count++;
  endtask

  task automatic serve(input host_cmd_t c);
    int beats;
    int nbytes;
    beat_t beat;
    beats = (int'(c.size) + BEAT_BYTES - 1) / BEAT_BYTES;
    for (int b = 0; b < beats; b++) begin
      @(negedge clock);
      if (c.code == READ_CL_NA) begin
        for (int k = 0; k < BEAT_BYTES; k++) begin
          beat[k*8 +: 8] = mem_byte(c.address + addr_t'(b * BEAT_BYTES + k));
        end
        write_valid = 1'b1;
        write_tag = c.tag;
        write_address = AW'(b);
        write_data = beat;
        @(negedge clock);
        write_valid = 1'b0;
      end else begin
        read_valid = 1'b1;
        read_tag = c.tag;
        read_address = AW'(b);
        @(negedge clock);
        read_valid = 1'b0;
        check_value("read_parity", 64'(read_parity), 64'(odd_parity(512'(read_data))));
        nbytes = int'(c.size) - b * BEAT_BYTES;
        for (int k = 0; k < BEAT_BYTES && k < nbytes; k++) begin
          memory[c.address + addr_t'(b * BEAT_BYTES + k)] = read_data[k*8 +: 8];
        end
      end
    end
    repeat (2) @(negedge clock);
    response_valid = 1'b1;
    response_tag = c.tag;
    @(negedge clock);
    response_valid = 1'b0;
    if (c.tag == DONE_WRITE) begin
      jobs_done++;
    end
  endtask

  always @(negedge clock) begin
    if (!reset && command_valid) begin
      check_command();
      pending.push_back(host_cmd_t'{command_code, command_tag, command_address, command_size});
    end
  end

  // host picks commands up on the rising edge, drives on the falling edge
  initial begin
    host_cmd_t c;
    forever begin
      @(posedge clock);
      if (pending.size() > 0) begin
        c = pending.pop_front();
        serve(c);
      end
    end
  end

  initial begin
    int budget;
    int j;
    job_t row;
    budget = 16;
    for (j = 0; j < NUM_JOBS; j++) begin
      row = job_row(j);
      budget += JOB_CYCLES + row.lines * LINE_CYCLES;
    end
    repeat (budget) @(posedge clock);
    $display("watchdog expired after %0d cycles before all jobs finished", budget);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    int j;
    int i;
    job_t row;
    rng_state = 32'h7b979ede;
    cmd_count = 0;
    jobs_done = 0;
    check_count = 0;
    error_count = 0;
    reset = 1'b1;
    enabled = 1'b0;
    wed = '0;
    write_valid = 1'b0;
    write_tag = '0;
    write_address = '0;
    write_data = '0;
    read_valid = 1'b0;
    read_tag = '0;
    read_address = '0;
    response_valid = 1'b0;
    response_tag = '0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    for (j = 0; j < NUM_JOBS; j++) begin
      row = job_row(j);
      load_job(row);
      current = row;
      cmd_count = 0;
      @(negedge clock);
      wed = row.wed;
      enabled = 1'b1;
      wait (jobs_done == j + 1);
      for (i = 0; i < row.lines * LINE_BYTES; i++) begin
        check_value("parity memory", 64'(mem_byte(row.parity + addr_t'(i))),
                    64'(mem_byte(row.stripe1 + addr_t'(i)) ^
                        mem_byte(row.stripe2 + addr_t'(i))));
      end
      check_value("done flag", 64'(mem_byte(row.wed + 64'd32)), 64'd1);
      @(negedge clock);
      enabled = 1'b0;
      repeat (4) @(negedge clock);
    end
    $display("checks %0d, errors %0d, assertion failures %0d",
             check_count, error_count, dut.chk.failures);
    if (error_count == 0 && dut.chk.failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- sim/parity_afu_chk.sv
`timescale 1ns/100ps

module parity_afu_chk import afu_pkg::*; (
  input logic clock,
  input logic reset,
  input logic enabled,
  input logic command_valid,
  input tag_t command_tag,
  input logic read_valid,
  input beat_t read_data
);

  int failures = 0;
  logic done_seen;

  // set by the done command, cleared once enabled drops
  always_ff @(posedge clock) begin
    if (reset) begin
      done_seen <= 1'b0;
    end else if (command_valid && command_tag == DONE_WRITE) begin
      done_seen <= 1'b1;
    end else if (!enabled) begin
      done_seen <= 1'b0;
    end
  end

  quiet_after_reset: assert property (@(posedge clock) (reset || $past(reset)) |=> !command_valid)
    else begin
      failures++;
      $error("command_valid high during reset or in the cycle after it");
    end

  read_latency: assert property (@(posedge clock) disable iff (reset)
    !$stable(read_data) |-> $past(read_valid))
    else begin
      failures++;
      $error("read_data changed without a read one cycle before");
    end

  quiet_after_done: assert property (@(posedge clock) disable iff (reset)
    done_seen |-> !command_valid)
    else begin
      failures++;
      $error("command issued after the done write while still enabled");
    end

endmodule

bind parity_afu parity_afu_chk chk (
  .clock(clock),
  .reset(reset),
  .enabled(enabled),
  .command_valid(command_valid),
  .command_tag(command_tag),
  .read_valid(read_valid),
  .read_data(read_data)
);

//--- src/parity_afu.sv
`timescale 1ns/100ps

module parity_afu import afu_pkg::*; #(
  parameter int LINE_BEATS = 2
) (
  input logic clock,
  input logic reset,
  input logic enabled,
  input addr_t wed,
  input logic write_valid,
  input tag_t write_tag,
  input logic [$clog2(LINE_BEATS)-1:0] write_address,
  input beat_t write_data,
  input logic read_valid,
  input tag_t read_tag,
  input logic [$clog2(LINE_BEATS)-1:0] read_address,
  input logic response_valid,
  input tag_t response_tag,
  output logic command_valid,
  output cmd_code_t command_code,
  output tag_t command_tag,
  output addr_t command_address,
  output size_t command_size,
  output logic command_parity,
  output logic tag_parity,
  output logic address_parity,
  output beat_t read_data,
  output logic read_parity
);

  cmd_if cmd ();

  parity_workelement #(
    .LINE_BEATS(LINE_BEATS)
  ) workelement (
    .clock(clock),
    .reset(reset),
    .enabled(enabled),
    .wed(wed),
    .write_valid(write_valid),
    .write_tag(write_tag),
    .write_address(write_address),
    .write_data(write_data),
    .response_valid(response_valid),
    .response_tag(response_tag),
    .cmd(cmd.issuer)
  );

  line_buffer #(
    .LINE_BEATS(LINE_BEATS)
  ) buffer (
    .clock(clock),
    .reset(reset),
    .write_valid(write_valid),
    .write_tag(write_tag),
    .write_address(write_address),
    .write_data(write_data),
    .read_valid(read_valid),
    .read_tag(read_tag),
    .read_address(read_address),
    .read_data(read_data),
    .read_parity(read_parity)
  );

  command_encoder encoder (
    .clock(clock),
    .reset(reset),
    .cmd(cmd.encoder),
    .command_valid(command_valid),
    .command_code(command_code),
    .command_tag(command_tag),
    .command_address(command_address),
    .command_size(command_size),
    .command_parity(command_parity),
    .tag_parity(tag_parity),
    .address_parity(address_parity)
  );

endmodule

//--- src/command_encoder.sv
`timescale 1ns/100ps

module command_encoder import afu_pkg::*; (
  input logic clock,
  input logic reset,
  cmd_if.encoder cmd,
  output logic command_valid,
  output cmd_code_t command_code,
  output tag_t command_tag,
  output addr_t command_address,
  output size_t command_size,
  output logic command_parity,
  output logic tag_parity,
  output logic address_parity
);

  always_ff @(posedge clock) begin
    if (reset) begin
      command_valid <= 1'b0;
    end else begin
      command_valid <= cmd.valid;
    end
  end

  // fields and their odd parity only change on a strobe
  always_ff @(posedge clock) begin
    if (cmd.valid) begin
      command_code <= cmd.command;
      command_tag <= cmd.tag;
      command_address <= cmd.address;
      command_size <= cmd.size;
      command_parity <= ~^cmd.command;
      tag_parity <= ~^cmd.tag;
      address_parity <= ~^cmd.address;
    end
  end

endmodule

//--- src/line_buffer.sv
`timescale 1ns/100ps

module line_buffer import afu_pkg::*; #(
  parameter int LINE_BEATS = 2
) (
  input logic clock,
  input logic reset,
  input logic write_valid,
  input tag_t write_tag,
  input logic [$clog2(LINE_BEATS)-1:0] write_address,
  input beat_t write_data,
  input logic read_valid,
  input tag_t read_tag,
  input logic [$clog2(LINE_BEATS)-1:0] read_address,
  output beat_t read_data,
  output logic read_parity
);

  // flag byte 1 in the first byte lane
  localparam beat_t DONE_BEAT = {8'h01, 504'd0};

  beat_t stripe1_line [LINE_BEATS];
  beat_t stripe2_line [LINE_BEATS];

  // WED beats are caught by the work element, not stored here
  always_ff @(posedge clock) begin
    if (write_valid) begin
      if (write_tag == STRIPE1_READ) begin
        stripe1_line[write_address] <= write_data;
      end else if (write_tag == STRIPE2_READ) begin
        stripe2_line[write_address] <= write_data;
      end
    end
  end

  // data appears one cycle after a read and holds until the next one
  always_ff @(posedge clock) begin
    if (reset) begin
      read_data <= '0;
    end else if (read_valid) begin
      case (read_tag)
        PARITY_WRITE: read_data <= stripe1_line[read_address] ^ stripe2_line[read_address];
        DONE_WRITE: read_data <= DONE_BEAT;
        default: read_data <= '0;
      endcase
    end
  end

  assign read_parity = ~^read_data;

endmodule

//--- src/parity_workelement.sv
`timescale 1ns/100ps

module parity_workelement import afu_pkg::*; #(
  parameter int LINE_BEATS = 2
) (
  input logic clock,
  input logic reset,
  input logic enabled,
  input addr_t wed,
  input logic write_valid,
  input tag_t write_tag,
  input logic [$clog2(LINE_BEATS)-1:0] write_address,
  input wed_beat_u write_data,
  input logic response_valid,
  input tag_t response_tag,
  cmd_if.issuer cmd
);

  we_state_t state;
  we_state_t next_state;

  // byte-swapped descriptor
  addr_t job_size;
  addr_t stripe1_base;
  addr_t stripe2_base;
  addr_t parity_base;

  addr_t offset;
  addr_t next_offset;
  logic stripe1_seen;
  logic stripe2_seen;
  logic stripe1_resp;
  logic stripe2_resp;

  assign next_offset = offset + addr_t'(LINE_BYTES);
  assign stripe1_resp = response_valid && response_tag == STRIPE1_READ;
  assign stripe2_resp = response_valid && response_tag == STRIPE2_READ;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: if (enabled) next_state = WED_REQ;
      WED_REQ: next_state = WED_WAIT;
      WED_WAIT: begin
        if (response_valid && response_tag == WED_TAG) next_state = READ_S1;
      end
      READ_S1: next_state = READ_S2;
      READ_S2: next_state = STRIPE_WAIT;
      STRIPE_WAIT: begin
        // responses may come back in either order
        if ((stripe1_seen || stripe1_resp) && (stripe2_seen || stripe2_resp)) begin
          next_state = WRITE_REQ;
        end
      end
      WRITE_REQ: next_state = WRITE_WAIT;
      WRITE_WAIT: begin
        if (response_valid && response_tag == PARITY_WRITE) begin
          next_state = (next_offset < job_size) ? READ_S1 : DONE_REQ;
        end
      end
      DONE_REQ: next_state = DONE_WAIT;
      DONE_WAIT: begin
        if (response_valid && response_tag == DONE_WRITE) next_state = FINISHED;
      end
      FINISHED: if (!enabled) next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  // descriptor arrives as beat 0 of the WED read
  always_ff @(posedge clock) begin
    if (state == WED_WAIT && write_valid && write_tag == WED_TAG && write_address == '0) begin
      job_size <= swap_endianness(write_data.desc.size);
      stripe1_base <= swap_endianness(write_data.desc.stripe1);
      stripe2_base <= swap_endianness(write_data.desc.stripe2);
      parity_base <= swap_endianness(write_data.desc.parity);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      offset <= '0;
      stripe1_seen <= 1'b0;
      stripe2_seen <= 1'b0;
    end else begin
      if (state == WED_REQ) begin
        offset <= '0;
      end else if (state == WRITE_WAIT && response_valid && response_tag == PARITY_WRITE &&
                   next_offset < job_size) begin
        offset <= next_offset;
      end
      if (state == READ_S1) begin
        stripe1_seen <= 1'b0;
        stripe2_seen <= 1'b0;
      end else if (state == STRIPE_WAIT) begin
        stripe1_seen <= stripe1_seen || stripe1_resp;
        stripe2_seen <= stripe2_seen || stripe2_resp;
      end
    end
  end

  // one strobe per request state
  always_comb begin
    cmd.valid = 1'b0;
    cmd.command = READ_CL_NA;
    cmd.tag = WED_TAG;
    cmd.address = wed;
    cmd.size = 12'd32;
    case (state)
      WED_REQ: cmd.valid = 1'b1;
      READ_S1: begin
        cmd.valid = 1'b1;
        cmd.tag = STRIPE1_READ;
        cmd.address = stripe1_base + offset;
        cmd.size = size_t'(LINE_BYTES);
      end
      READ_S2: begin
        cmd.valid = 1'b1;
        cmd.tag = STRIPE2_READ;
        cmd.address = stripe2_base + offset;
        cmd.size = size_t'(LINE_BYTES);
      end
      WRITE_REQ: begin
        cmd.valid = 1'b1;
        cmd.command = WRITE_NA;
        cmd.tag = PARITY_WRITE;
        cmd.address = parity_base + offset;
        cmd.size = size_t'(LINE_BYTES);
      end
      DONE_REQ: begin
        cmd.valid = 1'b1;
        cmd.command = WRITE_NA;
        cmd.tag = DONE_WRITE;
        cmd.address = wed + addr_t'(DONE_OFFSET);
        cmd.size = 12'd1;
      end
      default: ;
    endcase
  end

endmodule

//--- src/cmd_if.sv
`timescale 1ns/100ps

// one bus command per valid strobe
interface cmd_if import afu_pkg::*; ();

  logic valid;
  cmd_code_t command;
  tag_t tag;
  addr_t address;
  size_t size;

  modport issuer (
    output valid, command, tag, address, size
  );

  modport encoder (
    input valid, command, tag, address, size
  );

endinterface

//--- src/afu_pkg.sv
package afu_pkg;

  typedef logic [63:0] addr_t;
  typedef logic [7:0] tag_t;
  typedef logic [12:0] cmd_code_t;
  typedef logic [11:0] size_t;

  // beat bit 0 is the first byte on the bus
  typedef logic [0:511] beat_t;

  localparam cmd_code_t READ_CL_NA = 13'h0a00;
  localparam cmd_code_t WRITE_NA = 13'h0d00;

  localparam tag_t WED_TAG = 8'd0;
  localparam tag_t STRIPE1_READ = 8'd1;
  localparam tag_t STRIPE2_READ = 8'd2;
  localparam tag_t PARITY_WRITE = 8'd3;
  localparam tag_t DONE_WRITE = 8'd4;

  localparam int LINE_BYTES = 128;
  localparam int DONE_OFFSET = 32;

  typedef enum logic [3:0] {
    IDLE,
    WED_REQ,
    WED_WAIT,
    READ_S1,
    READ_S2,
    STRIPE_WAIT,
    WRITE_REQ,
    WRITE_WAIT,
    DONE_REQ,
    DONE_WAIT,
    FINISHED
  } we_state_t;

  // descriptor words still little-endian as stored in host memory
  typedef struct packed {
    addr_t size;
    addr_t stripe1;
    addr_t stripe2;
    addr_t parity;
    logic [0:255] pad;
  } wed_desc_t;

  typedef union packed {
    beat_t raw;
    wed_desc_t desc;
  } wed_beat_u;

  function automatic addr_t swap_endianness(input addr_t value);
    addr_t result;
    for (int i = 0; i < 8; i++) begin
      result[i*8 +: 8] = value[(7-i)*8 +: 8];
    end
    return result;
  endfunction

endpackage
